//--- rtl/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------------------------------------
    // Word and instruction field types.
    // ------------------------------------------------------------
    typedef logic [31:0] t_word;
    typedef logic [4:0]  t_reg_addr;
    typedef logic [6:0]  t_opcode;
    typedef logic [2:0]  t_funct3;

    // Class of ALU operation chosen by the control FSM.
    typedef logic [1:0]  t_alu_op;

    // Select for the ALU source and result multiplexers.
    typedef logic [1:0]  t_src_sel;

    // ------------------------------------------------------------
    // Major opcodes.
    // ------------------------------------------------------------
    localparam t_opcode OP_LOAD   = 7'b0000011;
    localparam t_opcode OP_STORE  = 7'b0100011;
    localparam t_opcode OP_ALU    = 7'b0110011;
    localparam t_opcode OP_ALUI   = 7'b0010011;
    localparam t_opcode OP_BRANCH = 7'b1100011;
    localparam t_opcode OP_JAL    = 7'b1101111;
    localparam t_opcode OP_JALR   = 7'b1100111;

endpackage

//--- rtl/ctrl_if.sv
interface ctrl_if import cpu_pkg::*; ();

    // Control levels from the FSM.
    t_alu_op  alu_op;
    t_src_sel result_src;
    t_src_sel alu_src_1;
    t_src_sel alu_src_2;
    logic     mem_addr_src;
    logic     reg_write_en;
    logic     pc_update;
    logic     mem_write_en;
    logic     instr_write_en;
    logic     branch;

    // Instruction fields back from the datapath.
    t_opcode  opcode;
    t_funct3  funct3;
    logic     funct7_5;

    modport fsm (
        output alu_op, result_src, alu_src_1, alu_src_2, mem_addr_src,
               reg_write_en, pc_update, mem_write_en, instr_write_en, branch,
        input  opcode, funct3, funct7_5
    );

    modport dp (
        input  alu_op, result_src, alu_src_1, alu_src_2, mem_addr_src,
               reg_write_en, pc_update, mem_write_en, instr_write_en, branch,
        output opcode, funct3, funct7_5
    );

endinterface

//--- rtl/alu.sv
module alu import cpu_pkg::*; (
    input  t_word   i_src_1,
    input  t_word   i_src_2,
    input  t_alu_op i_alu_op,
    input  t_funct3 i_funct3,
    input  logic    i_funct7_5,
    input  logic    i_op_5,
    output t_word   o_result,
    output logic    o_zero
);

    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;
    localparam logic [2:0] ALU_XOR = 3'd4;
    localparam logic [2:0] ALU_SLT = 3'd5;

    logic [2:0] alu_ctrl;

    // Operation select.
    always_comb begin
        alu_ctrl = ALU_ADD;
        if (i_alu_op == 2'b01) begin
            alu_ctrl = ALU_SUB;
        end else if (i_alu_op == 2'b10) begin
            case (i_funct3)
                3'b000:  alu_ctrl = (i_op_5 && i_funct7_5) ? ALU_SUB : ALU_ADD;
                3'b010:  alu_ctrl = ALU_SLT;
                3'b100:  alu_ctrl = ALU_XOR;
                3'b110:  alu_ctrl = ALU_OR;
                3'b111:  alu_ctrl = ALU_AND;
                default: alu_ctrl = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        case (alu_ctrl)
            ALU_SUB: o_result = i_src_1 - i_src_2;
            ALU_AND: o_result = i_src_1 & i_src_2;
            ALU_OR:  o_result = i_src_1 | i_src_2;
            ALU_XOR: o_result = i_src_1 ^ i_src_2;
            ALU_SLT: o_result = {31'b0, $signed(i_src_1) < $signed(i_src_2)};
            default: o_result = i_src_1 + i_src_2;
        endcase
    end

    assign o_zero = (o_result == '0);

endmodule

//--- rtl/reg_file.sv
module reg_file import cpu_pkg::*; (
    input  logic      clk,
    input  logic      arstn,
    input  t_reg_addr i_rs1,
    input  t_reg_addr i_rs2,
    input  t_reg_addr i_rd,
    input  t_word     i_wdata,
    input  logic      i_we,
    output t_word     o_rdata_1,
    output t_word     o_rdata_2
);

    t_word regs [32];

    // x0 is cleared here and never written, so it always reads zero.
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Combinational read ports.
    assign o_rdata_1 = regs[i_rs1];
    assign o_rdata_2 = regs[i_rs2];

endmodule

//--- rtl/main_fsm.sv
module main_fsm import cpu_pkg::*; (
    input logic clk,
    input logic arstn,
    ctrl_if.fsm ctrl
);

    typedef enum logic [3:0] {
        FETCH,
        DECODE,
        MEMADDR,
        MEMREAD,
        MEMWB,
        MEMWRITE,
        EXECUTER,
        EXECUTEI,
        ALUWB,
        JAL,
        BRANCH
    } t_state;

    typedef enum logic [2:0] {
        CLS_LOAD,
        CLS_STORE,
        CLS_ALU_R,
        CLS_ALU_I,
        CLS_BRANCH,
        CLS_JAL,
        CLS_JALR,
        CLS_NOP
    } t_class;

    t_state state;
    t_state next_state;
    t_class instr_class;

    // Instruction class from the major opcode.
    always_comb begin
        case (ctrl.opcode)
            OP_LOAD:   instr_class = CLS_LOAD;
            OP_STORE:  instr_class = CLS_STORE;
            OP_ALU:    instr_class = CLS_ALU_R;
            OP_ALUI:   instr_class = CLS_ALU_I;
            OP_BRANCH: instr_class = CLS_BRANCH;
            OP_JAL:    instr_class = CLS_JAL;
            OP_JALR:   instr_class = CLS_JALR;
            default:   instr_class = CLS_NOP;
        endcase
    end

    // ------------------------------------------------------------
    // State register and next state.
    // ------------------------------------------------------------
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = FETCH;
        case (state)
            FETCH: next_state = DECODE;
            DECODE: begin
                case (instr_class)
                    CLS_LOAD, CLS_STORE, CLS_JALR: next_state = MEMADDR;
                    CLS_ALU_R:  next_state = EXECUTER;
                    CLS_ALU_I:  next_state = EXECUTEI;
                    CLS_BRANCH: next_state = BRANCH;
                    CLS_JAL:    next_state = JAL;
                    default:    next_state = FETCH;
                endcase
            end
            MEMADDR: begin
                case (instr_class)
                    CLS_LOAD:  next_state = MEMREAD;
                    CLS_STORE: next_state = MEMWRITE;
                    CLS_JALR:  next_state = JAL;
                    default:   next_state = FETCH;
                endcase
            end
            MEMREAD:  next_state = MEMWB;
            EXECUTER: next_state = ALUWB;
            EXECUTEI: next_state = ALUWB;
            JAL:      next_state = ALUWB;
            default:  next_state = FETCH;
        endcase
    end

    // ------------------------------------------------------------
    // Control levels of the present state.
    // ------------------------------------------------------------
    always_comb begin
        ctrl.alu_op         = 2'b00;
        ctrl.result_src     = 2'b00;
        ctrl.alu_src_1      = 2'b00;
        ctrl.alu_src_2      = 2'b00;
        ctrl.mem_addr_src   = 1'b0;
        ctrl.reg_write_en   = 1'b0;
        ctrl.pc_update      = 1'b0;
        ctrl.mem_write_en   = 1'b0;
        ctrl.instr_write_en = 1'b0;
        ctrl.branch         = 1'b0;
        case (state)
            FETCH: begin
                // PC plus 4 goes straight back into the PC.
                ctrl.instr_write_en = 1'b1;
                ctrl.alu_src_2      = 2'b10;
                ctrl.result_src     = 2'b10;
                ctrl.pc_update      = 1'b1;
            end
            DECODE: begin
                // Branch or jump target into ALU-out.
                ctrl.alu_src_1 = 2'b01;
                ctrl.alu_src_2 = 2'b01;
            end
            MEMADDR: begin
                ctrl.alu_src_1 = 2'b10;
                ctrl.alu_src_2 = 2'b01;
            end
            MEMREAD: begin
                ctrl.mem_addr_src = 1'b1;
            end
            MEMWB: begin
                ctrl.result_src   = 2'b01;
                ctrl.reg_write_en = 1'b1;
            end
            MEMWRITE: begin
                ctrl.mem_addr_src = 1'b1;
                ctrl.mem_write_en = 1'b1;
            end
            EXECUTER: begin
                ctrl.alu_src_1 = 2'b10;
                ctrl.alu_op    = 2'b10;
            end
            EXECUTEI: begin
                ctrl.alu_src_1 = 2'b10;
                ctrl.alu_src_2 = 2'b01;
                ctrl.alu_op    = 2'b10;
            end
            ALUWB: begin
                ctrl.reg_write_en = 1'b1;
            end
            JAL: begin
                // Jump to ALU-out while the link value is formed.
                ctrl.alu_src_1 = 2'b01;
                ctrl.alu_src_2 = 2'b10;
                ctrl.pc_update = 1'b1;
            end
            BRANCH: begin
                ctrl.alu_src_1 = 2'b10;
                ctrl.alu_op    = 2'b01;
                ctrl.branch    = 1'b1;
            end
        endcase
    end

endmodule

//--- rtl/datapath.sv
module datapath import cpu_pkg::*; #(
    parameter t_word RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arstn,
    ctrl_if.dp    ctrl,
    input  t_word i_mem_rdata,
    output t_word o_mem_addr,
    output t_word o_mem_wdata,
    output logic  o_mem_we
);

    t_word pc;
    t_word old_pc;
    t_word instr;
    t_word data_reg;
    t_word reg_a;
    t_word reg_b;
    t_word alu_out;
    t_word imm_ext;
    t_word src_1;
    t_word src_2;
    t_word alu_result;
    t_word result;
    t_word rdata_1;
    t_word rdata_2;
    logic  alu_zero;
    logic  pc_write;

    assign ctrl.opcode   = instr[6:0];
    assign ctrl.funct3   = instr[14:12];
    assign ctrl.funct7_5 = instr[30];

    // ------------------------------------------------------------
    // Architectural and internal registers.
    // ------------------------------------------------------------
    assign pc_write = ctrl.pc_update || (ctrl.branch && alu_zero);

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            pc <= RESET_PC;
        end else if (pc_write) begin
            pc <= result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.instr_write_en) begin
            old_pc <= pc;
            instr  <= i_mem_rdata;
        end
        data_reg <= i_mem_rdata;
        reg_a    <= rdata_1;
        reg_b    <= rdata_2;
        alu_out  <= alu_result;
    end

    // Immediate format by opcode.
    always_comb begin
        case (ctrl.opcode)
            OP_STORE:  imm_ext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH: imm_ext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            OP_JAL:    imm_ext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default:   imm_ext = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // ------------------------------------------------------------
    // Source and result multiplexers.
    // ------------------------------------------------------------
    always_comb begin
        case (ctrl.alu_src_1)
            2'b00:   src_1 = pc;
            2'b01:   src_1 = old_pc;
            default: src_1 = reg_a;
        endcase
        case (ctrl.alu_src_2)
            2'b00:   src_2 = reg_b;
            2'b01:   src_2 = imm_ext;
            default: src_2 = 32'd4;
        endcase
        case (ctrl.result_src)
            2'b00:   result = alu_out;
            2'b01:   result = data_reg;
            default: result = alu_result;
        endcase
    end

    assign o_mem_addr  = ctrl.mem_addr_src ? result : pc;
    assign o_mem_wdata = reg_b;
    assign o_mem_we    = ctrl.mem_write_en;

    reg_file reg_file_inst (
        .clk       (clk),
        .arstn     (arstn),
        .i_rs1     (instr[19:15]),
        .i_rs2     (instr[24:20]),
        .i_rd      (instr[11:7]),
        .i_wdata   (result),
        .i_we      (ctrl.reg_write_en),
        .o_rdata_1 (rdata_1),
        .o_rdata_2 (rdata_2)
    );

    alu alu_inst (
        .i_src_1    (src_1),
        .i_src_2    (src_2),
        .i_alu_op   (ctrl.alu_op),
        .i_funct3   (ctrl.funct3),
        .i_funct7_5 (ctrl.funct7_5),
        .i_op_5     (ctrl.opcode[5]),
        .o_result   (alu_result),
        .o_zero     (alu_zero)
    );

endmodule

//--- rtl/cpu_top.sv
module cpu_top import cpu_pkg::*; #(
    parameter t_word RESET_PC = '0
) (
    input  logic  clk,
    input  logic  arstn,

    // Single word-addressed memory port.
    input  t_word i_mem_rdata,
    output t_word o_mem_addr,
    output t_word o_mem_wdata,
    output logic  o_mem_we
);

    ctrl_if ctrl ();

    // ------------------------------------------------------------
    // Control FSM and shared datapath.
    // ------------------------------------------------------------
    main_fsm main_fsm_inst (
        .clk   (clk),
        .arstn (arstn),
        .ctrl  (ctrl.fsm)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) datapath_inst (
        .clk         (clk),
        .arstn       (arstn),
        .ctrl        (ctrl.dp),
        .i_mem_rdata (i_mem_rdata),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .o_mem_we    (o_mem_we)
    );

endmodule

//--- verification/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic arstn
);

    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Reset held over two rising edges, released just after the second.
    initial begin
        arstn = 1'b0;
        repeat (2) @(posedge clk);
        #1 arstn = 1'b1;
    end

endmodule

//--- verification/tb_cpu.sv
module tb_cpu import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam t_word RESET_PC   = 32'h0000_0000;
    localparam t_word DATA_ADDR  = 32'h0000_0200;
    localparam t_word RES_ADDR   = 32'h0000_0300;
    localparam t_word WRONG_ADDR = 32'h0000_03F0;
    localparam t_word DONE_ADDR  = 32'h0000_03FC;
    localparam int    RESET_WAIT = 10;
    localparam int    RUN_WAIT   = 2000;

    logic  clk;
    logic  arstn;
    t_word mem_rdata;
    t_word mem_addr;
    t_word mem_wdata;
    logic  mem_we;

    t_word mem [256];
    t_word exp_addr [$];
    t_word exp_data [$];
    t_word word_a;
    t_word word_b;
    t_word wr_addr;
    t_word wr_data;
    logic  wr_pending   = 1'b0;
    logic  done         = 1'b0;
    int    prog_len     = 0;
    int    wait_cycles  = 0;
    int    store_count  = 0;
    int    value_errors = 0;
    int    other_errors = 0;

    clk_gen clk_gen_inst (
        .clk   (clk),
        .arstn (arstn)
    );

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) cpu_top_inst (
        .clk         (clk),
        .arstn       (arstn),
        .i_mem_rdata (mem_rdata),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .o_mem_we    (mem_we)
    );

    // ------------------------------------------------------------
    // Instruction encoders, operands in assembly order.
    // ------------------------------------------------------------
    function automatic t_word r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OP_ALU};
    endfunction

    function automatic t_word i_type(input logic [6:0] opc, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic t_word s_type(input logic [4:0] rs2, input logic [11:0] imm,
                                     input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic t_word b_type(input logic [4:0] rs1, input logic [4:0] rs2,
                                     input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic t_word j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic place(input t_word instr);
        mem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_program();
        // 0x00: operands, then register ALU ops, each stored.
        place(i_type(OP_LOAD, 3'b010, 5'd1, 5'd0, 12'h200));
        place(i_type(OP_LOAD, 3'b010, 5'd2, 5'd0, 12'h204));
        place(r_type(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2));
        place(s_type(5'd3, 12'h300, 5'd0));
        place(r_type(7'b0100000, 3'b000, 5'd3, 5'd1, 5'd2));
        place(s_type(5'd3, 12'h304, 5'd0));
        place(r_type(7'b0000000, 3'b111, 5'd3, 5'd1, 5'd2));
        place(s_type(5'd3, 12'h308, 5'd0));
        place(r_type(7'b0000000, 3'b110, 5'd3, 5'd1, 5'd2));
        place(s_type(5'd3, 12'h30C, 5'd0));
        place(r_type(7'b0000000, 3'b100, 5'd3, 5'd1, 5'd2));
        place(s_type(5'd3, 12'h310, 5'd0));
        place(r_type(7'b0000000, 3'b010, 5'd3, 5'd1, 5'd2));
        place(s_type(5'd3, 12'h314, 5'd0));
        // 0x38: immediate ops on the first word.
        place(i_type(OP_ALUI, 3'b000, 5'd4, 5'd1, 12'hFFB));
        place(s_type(5'd4, 12'h318, 5'd0));
        place(i_type(OP_ALUI, 3'b111, 5'd4, 5'd1, 12'h0F0));
        place(s_type(5'd4, 12'h31C, 5'd0));
        place(i_type(OP_ALUI, 3'b110, 5'd4, 5'd1, 12'hF00));
        place(s_type(5'd4, 12'h320, 5'd0));
        place(i_type(OP_ALUI, 3'b100, 5'd4, 5'd1, 12'h7FF));
        place(s_type(5'd4, 12'h324, 5'd0));
        place(i_type(OP_ALUI, 3'b010, 5'd4, 5'd1, 12'h000));
        place(s_type(5'd4, 12'h328, 5'd0));
        // 0x60: taken beq skips a wrong-path store.
        place(b_type(5'd1, 5'd1, 13'd8));
        place(s_type(5'd1, 12'h3F0, 5'd0));
        place(i_type(OP_ALUI, 3'b000, 5'd5, 5'd0, 12'd7));
        // 0x6C: not-taken beq falls through to its store.
        place(b_type(5'd5, 5'd0, 13'd8));
        place(s_type(5'd5, 12'h32C, 5'd0));
        // 0x74: jal to 0x7C, link 0x78.
        place(j_type(5'd6, 21'd8));
        place(s_type(5'd5, 12'h3F0, 5'd0));
        place(s_type(5'd6, 12'h330, 5'd0));
        // 0x80: jalr to 0x90, link 0x84.
        place(i_type(OP_JALR, 3'b000, 5'd7, 5'd0, 12'h090));
        place(s_type(5'd5, 12'h3F0, 5'd0));
        place(s_type(5'd5, 12'h3F0, 5'd0));
        place(s_type(5'd5, 12'h3F0, 5'd0));
        place(s_type(5'd7, 12'h334, 5'd0));
        // 0x94: lui x8 is not supported and leaves x8 at zero.
        place({20'h12345, 5'd8, 7'b0110111});
        place(s_type(5'd8, 12'h338, 5'd0));
        place(s_type(5'd5, 12'h3FC, 5'd0));
        // Park on a self jump.
        place(j_type(5'd0, 21'd0));
    endtask

    task automatic add_expected(input t_word addr, input t_word data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic predict_stores();
        add_expected(RES_ADDR + 32'h00, word_a + word_b);
        add_expected(RES_ADDR + 32'h04, word_a - word_b);
        add_expected(RES_ADDR + 32'h08, word_a & word_b);
        add_expected(RES_ADDR + 32'h0C, word_a | word_b);
        add_expected(RES_ADDR + 32'h10, word_a ^ word_b);
        add_expected(RES_ADDR + 32'h14, ($signed(word_a) < $signed(word_b)) ? 32'd1 : 32'd0);
        add_expected(RES_ADDR + 32'h18, word_a + 32'hFFFF_FFFB);
        add_expected(RES_ADDR + 32'h1C, word_a & 32'h0000_00F0);
        add_expected(RES_ADDR + 32'h20, word_a | 32'hFFFF_FF00);
        add_expected(RES_ADDR + 32'h24, word_a ^ 32'h0000_07FF);
        add_expected(RES_ADDR + 32'h28, ($signed(word_a) < 0) ? 32'd1 : 32'd0);
        add_expected(RES_ADDR + 32'h2C, 32'd7);
        add_expected(RES_ADDR + 32'h30, 32'h0000_0078);
        add_expected(RES_ADDR + 32'h34, 32'h0000_0084);
        add_expected(RES_ADDR + 32'h38, 32'd0);
        add_expected(DONE_ADDR, 32'd7);
    endtask

    task automatic check_store(input t_word addr, input t_word data);
        t_word want_addr;
        t_word want_data;
        store_count++;
        assert (addr != WRONG_ADDR) else begin
            other_errors++;
            $display("Store reached the wrong-path address 0x%08h", addr);
        end
        assert (exp_addr.size() != 0) else begin
            other_errors++;
            $display("Store to 0x%08h after the last expected store", addr);
        end
        if (addr != WRONG_ADDR && exp_addr.size() != 0) begin
            want_addr = exp_addr.pop_front();
            want_data = exp_data.pop_front();
            assert (addr == want_addr) else begin
                value_errors++;
                $display("Error: o_mem_addr is 0x%08h, expected 0x%08h", addr, want_addr);
            end
            assert (data == want_data) else begin
                value_errors++;
                $display("Error: o_mem_wdata at 0x%08h is 0x%08h, expected 0x%08h",
                         addr, data, want_data);
            end
        end
        if (addr == DONE_ADDR) begin
            done = 1'b1;
        end
    endtask

    // ------------------------------------------------------------
    // Memory model and bus monitor.
    // ------------------------------------------------------------
    assign mem_rdata = mem[mem_addr[9:2]];

    // Bus sampled mid cycle.
    always @(negedge clk) begin
        wr_pending <= arstn && mem_we;
        wr_addr    <= mem_addr;
        wr_data    <= mem_wdata;
        if (!arstn) begin
            assert (!mem_we) else begin
                other_errors++;
                $display("Memory write enabled during reset");
            end
        end else begin
            assert (mem_addr[1:0] == 2'b00) else begin
                value_errors++;
                $display("Error: o_mem_addr 0x%08h is not word aligned", mem_addr);
            end
            if (mem_we) begin
                check_store(mem_addr, mem_wdata);
            end
        end
    end

    // Write lands 1 ns after the rising edge.
    always @(posedge clk) begin
        if (wr_pending) begin
            #1;
            mem[wr_addr[9:2]] = wr_data;
        end
    end

    initial begin
        word_a = $urandom(32'h2230);
        word_b = $urandom();
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hA5A5_0000 ^ (i << 2);
        end
        mem[DATA_ADDR[9:2]]     = word_a;
        mem[DATA_ADDR[9:2] + 1] = word_b;
        load_program();
        predict_stores();

        while (arstn !== 1'b1 && wait_cycles < RESET_WAIT) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (arstn !== 1'b1) begin
            other_errors++;
            $display("Timed out waiting for reset release");
        end else begin
            // First cycle out of reset is the first fetch.
            assert (mem_addr == RESET_PC) else begin
                value_errors++;
                $display("Error: o_mem_addr after reset is 0x%08h, expected 0x%08h",
                         mem_addr, RESET_PC);
            end
            wait_cycles = 0;
            while (!done && wait_cycles < RUN_WAIT) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (!done) begin
                other_errors++;
                $display("Timed out waiting for the store to the done address");
            end else begin
                // Let the parked loop run to catch stray stores.
                repeat (8) @(posedge clk);
                assert (exp_addr.size() == 0) else begin
                    other_errors++;
                    $display("%0d expected stores never happened", exp_addr.size());
                end
            end
        end

        $display("Stores checked: %0d, value errors: %0d, other errors: %0d",
                 store_count, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/cpu_pkg.sv
rtl/ctrl_if.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/main_fsm.sv
rtl/datapath.sv
rtl/cpu_top.sv
verification/clk_gen.sv
verification/tb_cpu.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module tb_cpu -f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/Vtb_cpu)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
